/* noc_pkg.sv */
/*
 * Shared definitions for the 3D mesh NoC
 * Mesh extent, node numbering widths, flit layout,
 * input buffer depth and the router direction enum
 */

package noc_pkg;

  //////////////////////////////////////////////////
  // Mesh geometry
  //////////////////////////////////////////////////

  // Extent per dimension
  localparam int MESH_X = 2;
  localparam int MESH_Y = 2;
  localparam int MESH_Z = 2;

  // Node n = x + y*MESH_X + z*MESH_X*MESH_Y
  localparam int NODES   = MESH_X * MESH_Y * MESH_Z;
  localparam int NODE_W  = $clog2(NODES);
  localparam int COORD_W = $clog2(MESH_X);

  //////////////////////////////////////////////////
  // Flit layout and buffering
  //////////////////////////////////////////////////

  localparam int FLIT_WIDTH = 34;
  // Destination node sits in the top NODE_W bits of a head flit
  localparam int DEST_LSB   = FLIT_WIDTH - NODE_W;

  // Input FIFO entries, pointer and fill count widths
  localparam int BUFFER_DEPTH = 4;
  localparam int BUF_PTR_W    = $clog2(BUFFER_DEPTH);
  localparam int BUF_CNT_W    = $clog2(BUFFER_DEPTH + 1);

  // Router ports and port index width
  localparam int PORTS  = 7;
  localparam int PORT_W = $clog2(PORTS);

  // Port order, also the route decision encoding
  typedef enum logic [PORT_W-1:0] {
    LOCAL = 3'd0,
    UP    = 3'd1,
    NORTH = 3'd2,
    EAST  = 3'd3,
    DOWN  = 3'd4,
    SOUTH = 3'd5,
    WEST  = 3'd6
  } dir_e;

endpackage

/* noc_input_buffer.sv */
/*
 * Router input FIFO
 * Circular buffer of flits with last markers,
 * valid/ready handshake on both sides
 */

`timescale 1ns/1ps

module noc_input_buffer
  import noc_pkg::*;
(
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic [FLIT_WIDTH-1:0] in_flit,
  input  logic                  in_last,
  input  logic                  in_valid,
  output logic                  in_ready,
  output logic [FLIT_WIDTH-1:0] out_flit,
  output logic                  out_last,
  output logic                  out_valid,
  input  logic                  out_ready
);

  // Storage, no reset needed on payload
  logic [FLIT_WIDTH-1:0] flit_mem [BUFFER_DEPTH];
  logic                  last_mem [BUFFER_DEPTH];

  logic [BUF_PTR_W-1:0] wr_ptr;
  logic [BUF_PTR_W-1:0] rd_ptr;
  logic [BUF_CNT_W-1:0] count;
  logic                 push;
  logic                 pop;

  assign push = in_valid && in_ready;
  assign pop  = out_valid && out_ready;

  // Accept while there is room
  assign in_ready  = (count < BUF_CNT_W'(BUFFER_DEPTH));
  // Head entry goes out directly
  assign out_valid = (count != '0);
  assign out_flit  = flit_mem[rd_ptr];
  assign out_last  = last_mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (push) begin
      flit_mem[wr_ptr] <= in_flit;
      last_mem[wr_ptr] <= in_last;
    end
  end

  // Pointers wrap at BUFFER_DEPTH
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == BUF_PTR_W'(BUFFER_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == BUF_PTR_W'(BUFFER_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // Simultaneous push and pop leaves the count alone
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (!push && pop) begin
        count <= count - 1'b1;
      end
    end
  end

  // Fill count never passes the depth and matches the pointer distance
  a_no_write_when_full: assert property (
    @(posedge clk) disable iff (!arst_n)
    (count <= BUF_CNT_W'(BUFFER_DEPTH)) &&
      (BUF_PTR_W'(wr_ptr - rd_ptr) == BUF_PTR_W'(count))
  );

endmodule

/* noc_route_lookup.sv */
/*
 * Dimension-order route decision for one input port
 * X first, then Y, then Z, LOCAL at the destination
 * Route is held from head flit to last flit
 */

`timescale 1ns/1ps

module noc_route_lookup
  import noc_pkg::*;
#(
  parameter int NODE_X = 0,
  parameter int NODE_Y = 0,
  parameter int NODE_Z = 0
) (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic [FLIT_WIDTH-1:0] flit,
  input  logic                  last,
  input  logic                  valid,
  input  logic                  accepted,
  output dir_e                  route
);

  logic [NODE_W-1:0]  dest;
  logic [COORD_W-1:0] dest_x;
  logic [COORD_W-1:0] dest_y;
  logic [COORD_W-1:0] dest_z;
  dir_e               next_route;
  dir_e               held_route;
  logic               active;
  logic               head_go;

  // Split node number into coordinates
  assign dest   = flit[DEST_LSB +: NODE_W];
  assign dest_x = COORD_W'(dest % MESH_X);
  assign dest_y = COORD_W'((dest / MESH_X) % MESH_Y);
  assign dest_z = COORD_W'(dest / (MESH_X * MESH_Y));

  // Only meaningful while a head flit sits at the buffer output
  always_comb begin
    if (int'(dest_x) != NODE_X) begin
      next_route = (int'(dest_x) > NODE_X) ? EAST : WEST;
    end else if (int'(dest_y) != NODE_Y) begin
      next_route = (int'(dest_y) > NODE_Y) ? NORTH : SOUTH;
    end else if (int'(dest_z) != NODE_Z) begin
      next_route = (int'(dest_z) > NODE_Z) ? UP : DOWN;
    end else begin
      next_route = LOCAL;
    end
  end

  assign head_go = valid && accepted && !active;

  // Body flits carry payload, not a destination
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      active     <= 1'b0;
      held_route <= LOCAL;
    end else if (head_go && !last) begin
      active     <= 1'b1;
      held_route <= next_route;
    end else if (active && valid && accepted && last) begin
      active <= 1'b0;
    end
  end

  assign route = active ? held_route : next_route;

endmodule

/* noc_output_arbiter.sv */
/*
 * Round-robin arbiter for one router output
 * Grant locks from head flit until last flit fires,
 * then priority moves past the winner
 */

`timescale 1ns/1ps

module noc_output_arbiter
  import noc_pkg::*;
(
  input  logic             clk,
  input  logic             arst_n,
  input  logic [PORTS-1:0] request,
  input  logic             last,
  input  logic             fire,
  output logic [PORTS-1:0] grant
);

  logic [PORT_W-1:0] ptr;
  logic [PORT_W-1:0] win_idx;
  logic              locked;
  logic [PORTS-1:0]  held_grant;
  logic [PORTS-1:0]  free_grant;

  //////////////////////////////////////////////////
  // Arbitration
  //////////////////////////////////////////////////

  // First requester at or after ptr wins
  always_comb begin
    int idx;
    free_grant = '0;
    for (int i = 0; i < PORTS; i++) begin
      idx = (int'(ptr) + i) % PORTS;
      if (request[idx] && (free_grant == '0)) begin
        free_grant[idx] = 1'b1;
      end
    end
  end

  // Free output grants in the same cycle
  assign grant = locked ? held_grant : free_grant;

  // Index of the current winner
  always_comb begin
    win_idx = '0;
    for (int i = 0; i < PORTS; i++) begin
      if (grant[i]) begin
        win_idx = PORT_W'(i);
      end
    end
  end

  //////////////////////////////////////////////////
  // Packet lock and priority pointer
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      locked     <= 1'b0;
      held_grant <= '0;
      ptr        <= '0;
    end else if (fire && last) begin
      // Packet done, release and rotate
      locked <= 1'b0;
      ptr    <= (win_idx == PORT_W'(PORTS - 1)) ? '0 : win_idx + 1'b1;
    end else if (!locked && (free_grant != '0)) begin
      // Keep the head flit offered until the packet ends
      locked     <= 1'b1;
      held_grant <= free_grant;
    end
  end

  a_grant_onehot0: assert property (
    @(posedge clk) disable iff (!arst_n)
    $onehot0(grant)
  );

endmodule

/* noc_router.sv */
/*
 * Seven-port wormhole router
 * Input FIFOs, route lookups, output arbiters
 * and the grant-driven crossbar
 */

`timescale 1ns/1ps

module noc_router
  import noc_pkg::*;
#(
  parameter int NODE_X = 0,
  parameter int NODE_Y = 0,
  parameter int NODE_Z = 0
) (
  input  logic                             clk,
  input  logic                             arst_n,
  input  logic [PORTS-1:0][FLIT_WIDTH-1:0] in_flit,
  input  logic [PORTS-1:0]                 in_last,
  input  logic [PORTS-1:0]                 in_valid,
  output logic [PORTS-1:0]                 in_ready,
  output logic [PORTS-1:0][FLIT_WIDTH-1:0] out_flit,
  output logic [PORTS-1:0]                 out_last,
  output logic [PORTS-1:0]                 out_valid,
  input  logic [PORTS-1:0]                 out_ready
);

  // Buffered side of each input port
  logic [PORTS-1:0][FLIT_WIDTH-1:0] buf_flit;
  logic [PORTS-1:0]                 buf_last;
  logic [PORTS-1:0]                 buf_valid;
  logic [PORTS-1:0]                 buf_ready;
  dir_e                             route [PORTS];

  // Indexed [output][input]
  logic [PORTS-1:0][PORTS-1:0] request;
  logic [PORTS-1:0][PORTS-1:0] grant;

  //////////////////////////////////////////////////
  // Input side
  //////////////////////////////////////////////////

  for (genvar i = 0; i < PORTS; i++) begin : g_in
    noc_input_buffer i_buffer (
      .clk       (clk),
      .arst_n    (arst_n),
      .in_flit   (in_flit[i]),
      .in_last   (in_last[i]),
      .in_valid  (in_valid[i]),
      .in_ready  (in_ready[i]),
      .out_flit  (buf_flit[i]),
      .out_last  (buf_last[i]),
      .out_valid (buf_valid[i]),
      .out_ready (buf_ready[i])
    );

    noc_route_lookup #(
      .NODE_X (NODE_X),
      .NODE_Y (NODE_Y),
      .NODE_Z (NODE_Z)
    ) i_route (
      .clk      (clk),
      .arst_n   (arst_n),
      .flit     (buf_flit[i]),
      .last     (buf_last[i]),
      .valid    (buf_valid[i]),
      .accepted (buf_valid[i] && buf_ready[i]),
      .route    (route[i])
    );

    // Ready goes back only through the output that granted this input
    always_comb begin
      buf_ready[i] = 1'b0;
      for (int o = 0; o < PORTS; o++) begin
        buf_ready[i] = buf_ready[i] | (grant[o][i] & out_ready[o]);
      end
    end
  end

  //////////////////////////////////////////////////
  // Output side and crossbar
  //////////////////////////////////////////////////

  for (genvar o = 0; o < PORTS; o++) begin : g_out
    for (genvar i = 0; i < PORTS; i++) begin : g_req
      assign request[o][i] = buf_valid[i] && (route[i] == dir_e'(o));
    end

    noc_output_arbiter i_arbiter (
      .clk     (clk),
      .arst_n  (arst_n),
      .request (request[o]),
      .last    (out_last[o]),
      .fire    (out_valid[o] && out_ready[o]),
      .grant   (grant[o])
    );

    // Mux by grant, zero when idle
    always_comb begin
      out_flit[o] = '0;
      out_last[o] = 1'b0;
      for (int i = 0; i < PORTS; i++) begin
        if (grant[o][i]) begin
          out_flit[o] = buf_flit[i];
          out_last[o] = buf_last[i];
        end
      end
    end

    assign out_valid[o] = |(grant[o] & buf_valid);

    // Stalled output keeps its flit until taken
    a_out_stable: assert property (
      @(posedge clk) disable iff (!arst_n)
      out_valid[o] && !out_ready[o] |=>
        out_valid[o] && $stable(out_flit[o]) && $stable(out_last[o])
    );
  end

endmodule

/* noc_mesh3d.sv */
/*
 * Top level 3D mesh NoC
 * One router per node, neighbor links,
 * border tie-off and local port wiring
 */

`timescale 1ns/1ps

module noc_mesh3d
  import noc_pkg::*;
(
  input  logic                             clk,
  input  logic                             arst_n,
  input  logic [NODES-1:0][FLIT_WIDTH-1:0] in_flit,
  input  logic [NODES-1:0]                 in_last,
  input  logic [NODES-1:0]                 in_valid,
  output logic [NODES-1:0]                 in_ready,
  output logic [NODES-1:0][FLIT_WIDTH-1:0] out_flit,
  output logic [NODES-1:0]                 out_last,
  output logic [NODES-1:0]                 out_valid,
  input  logic [NODES-1:0]                 out_ready
);

  // Does direction d lead to another node
  function automatic bit has_nb(int x, int y, int z, int d);
    case (d)
      UP:      return z < MESH_Z - 1;
      DOWN:    return z > 0;
      NORTH:   return y < MESH_Y - 1;
      SOUTH:   return y > 0;
      EAST:    return x < MESH_X - 1;
      WEST:    return x > 0;
      default: return 1'b0;
    endcase
  endfunction

  // Neighbor node number in direction d
  function automatic int nb_of(int x, int y, int z, int d);
    int n;
    n = x + y * MESH_X + z * MESH_X * MESH_Y;
    case (d)
      UP:      return n + MESH_X * MESH_Y;
      DOWN:    return n - MESH_X * MESH_Y;
      NORTH:   return n + MESH_X;
      SOUTH:   return n - MESH_X;
      EAST:    return n + 1;
      WEST:    return n - 1;
      default: return n;
    endcase
  endfunction

  // UP<->DOWN, NORTH<->SOUTH, EAST<->WEST
  function automatic int opposite(int d);
    return (d <= 3) ? d + 3 : d - 3;
  endfunction

  // Per-node router port bundles
  wire [PORTS-1:0][FLIT_WIDTH-1:0] node_in_flit   [NODES];
  wire [PORTS-1:0]                 node_in_last   [NODES];
  wire [PORTS-1:0]                 node_in_valid  [NODES];
  wire [PORTS-1:0]                 node_in_ready  [NODES];
  wire [PORTS-1:0][FLIT_WIDTH-1:0] node_out_flit  [NODES];
  wire [PORTS-1:0]                 node_out_last  [NODES];
  wire [PORTS-1:0]                 node_out_valid [NODES];
  wire [PORTS-1:0]                 node_out_ready [NODES];

  //////////////////////////////////////////////////
  // Routers and links
  //////////////////////////////////////////////////

  for (genvar z = 0; z < MESH_Z; z++) begin : g_z
    for (genvar y = 0; y < MESH_Y; y++) begin : g_y
      for (genvar x = 0; x < MESH_X; x++) begin : g_x
        localparam int N = x + y * MESH_X + z * MESH_X * MESH_Y;

        noc_router #(
          .NODE_X (x),
          .NODE_Y (y),
          .NODE_Z (z)
        ) i_router (
          .clk       (clk),
          .arst_n    (arst_n),
          .in_flit   (node_in_flit[N]),
          .in_last   (node_in_last[N]),
          .in_valid  (node_in_valid[N]),
          .in_ready  (node_in_ready[N]),
          .out_flit  (node_out_flit[N]),
          .out_last  (node_out_last[N]),
          .out_valid (node_out_valid[N]),
          .out_ready (node_out_ready[N])
        );

        // Local port to the external arrays
        assign node_in_flit[N][LOCAL]   = in_flit[N];
        assign node_in_last[N][LOCAL]   = in_last[N];
        assign node_in_valid[N][LOCAL]  = in_valid[N];
        assign in_ready[N]              = node_in_ready[N][LOCAL];
        assign out_flit[N]              = node_out_flit[N][LOCAL];
        assign out_last[N]              = node_out_last[N][LOCAL];
        assign out_valid[N]             = node_out_valid[N][LOCAL];
        assign node_out_ready[N][LOCAL] = out_ready[N];

        // Input d is fed by the neighbor's opposite output
        for (genvar d = 1; d < PORTS; d++) begin : g_link
          if (has_nb(x, y, z, d)) begin : g_nb
            localparam int M = nb_of(x, y, z, d);
            localparam int P = opposite(d);
            assign node_in_flit[N][d]   = node_out_flit[M][P];
            assign node_in_last[N][d]   = node_out_last[M][P];
            assign node_in_valid[N][d]  = node_out_valid[M][P];
            assign node_out_ready[N][d] = node_in_ready[M][P];
          end else begin : g_border
            // Idle border port, never valid, never ready
            assign node_in_flit[N][d]   = '0;
            assign node_in_last[N][d]   = 1'b0;
            assign node_in_valid[N][d]  = 1'b0;
            assign node_out_ready[N][d] = 1'b0;
          end
        end
      end
    end
  end

endmodule

/* tb_noc_mesh3d.sv */
/*
 * Testbench for the 3D mesh NoC
 * Clock and reset, per-source traffic queues, reference
 * destination function, scoreboard per source-destination
 * pair and the comparing process
 */

`timescale 1ns/1ps

module tb_noc_mesh3d
  import noc_pkg::*;
();

  // Flit fields below the destination: source, sequence, flit index
  localparam int SRC_LSB     = DEST_LSB - NODE_W;
  localparam int SEQ_LSB     = 12;
  localparam int SEQ_W       = 16;
  localparam int DRIVE_LIMIT = 20000;
  localparam int DRAIN_LIMIT = 5000;

  logic                             clk;
  logic                             arst_n;
  logic [NODES-1:0][FLIT_WIDTH-1:0] in_flit;
  logic [NODES-1:0]                 in_last;
  logic [NODES-1:0]                 in_valid;
  logic [NODES-1:0]                 in_ready;
  logic [NODES-1:0][FLIT_WIDTH-1:0] out_flit;
  logic [NODES-1:0]                 out_last;
  logic [NODES-1:0]                 out_valid;
  logic [NODES-1:0]                 out_ready;

  // Entries are {last, flit}
  logic [FLIT_WIDTH:0] tx_q [NODES][$];
  logic [FLIT_WIDTH:0] sb_q [NODES*NODES][$];
  int                  seq_num [NODES];
  // Source of the packet in progress per output, -1 when idle
  int                  cur_src [NODES];
  int                  seed;
  int                  sent;
  int                  received;
  bit                  ready_random;

  noc_mesh3d i_noc_mesh3d (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_flit   (in_flit),
    .in_last   (in_last),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .out_flit  (out_flit),
    .out_last  (out_last),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  task automatic stop_run(input string line);
    $display("%s", line);
    $display("Test failed");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                             input string what);
    if (actual !== expected) begin
      stop_run($sformatf("[ERROR] %0t ns: %s, got 0x%0h, expected 0x%0h",
                         $time, what, actual, expected));
    end
  endtask

  // Destination node from the head flit by x + y*MESH_X + z*MESH_X*MESH_Y
  function automatic int expected_node(input logic [FLIT_WIDTH-1:0] head);
    int dest;
    int x;
    int y;
    int z;
    dest = int'(head[DEST_LSB +: NODE_W]);
    x    = dest % MESH_X;
    y    = (dest / MESH_X) % MESH_Y;
    z    = dest / (MESH_X * MESH_Y);
    return x + y * MESH_X + z * MESH_X * MESH_Y;
  endfunction

  function automatic logic [FLIT_WIDTH-1:0] build_flit(input int src, input int dest,
                                                       input int seq, input int idx);
    logic [FLIT_WIDTH-1:0] f;
    f = '0;
    f[DEST_LSB +: NODE_W] = NODE_W'(dest);
    f[SRC_LSB +: NODE_W]  = NODE_W'(src);
    f[SEQ_LSB +: SEQ_W]   = SEQ_W'(seq);
    f[0 +: SEQ_LSB]       = SEQ_LSB'(idx);
    return f;
  endfunction

  // Same flits go to the source queue and the scoreboard of the expected node
  task automatic queue_packet(input int src, input int dest, input int len);
    logic [FLIT_WIDTH:0] entry;
    int                  node;
    node = expected_node(build_flit(src, dest, seq_num[src], 0));
    for (int i = 0; i < len; i++) begin
      entry = {(i == len - 1), build_flit(src, dest, seq_num[src], i)};
      tx_q[src].push_back(entry);
      sb_q[src * NODES + node].push_back(entry);
      sent++;
    end
    seq_num[src]++;
  endtask

  function automatic int pending();
    int total;
    total = 0;
    for (int k = 0; k < NODES * NODES; k++) begin
      total += sb_q[k].size();
    end
    return total;
  endfunction

  // All sources in parallel, one flit per source per handshake
  task automatic drive_all();
    logic [FLIT_WIDTH:0] entry;
    int                  cycles;
    bit                  busy;
    cycles = 0;
    busy   = 1'b1;
    while (busy) begin
      @(posedge clk);
      busy = 1'b0;
      for (int s = 0; s < NODES; s++) begin
        // Flit taken at this edge
        if (in_valid[s] && in_ready[s]) begin
          void'(tx_q[s].pop_front());
        end
        if (tx_q[s].size() > 0) begin
          entry        = tx_q[s][0];
          in_flit[s]  <= entry[FLIT_WIDTH-1:0];
          in_last[s]  <= entry[FLIT_WIDTH];
          in_valid[s] <= 1'b1;
          busy         = 1'b1;
        end else begin
          in_valid[s] <= 1'b0;
        end
      end
      cycles++;
      if (cycles > DRIVE_LIMIT) begin
        stop_run("Timeout: the sources could not hand all flits to the mesh");
      end
    end
  endtask

  task automatic wait_drain();
    int cycles;
    cycles = 0;
    while (pending() != 0) begin
      @(posedge clk);
      cycles++;
      if (cycles > DRAIN_LIMIT) begin
        stop_run("Timeout: flits still missing at their destinations");
      end
    end
    // Room for late duplicates to show up
    repeat (20) @(posedge clk);
  endtask

  //////////////////////////////////////////////////
  // Output side: back-pressure and comparison
  //////////////////////////////////////////////////

  always @(posedge clk) begin
    if (ready_random) begin
      out_ready <= NODES'($random(seed));
    end else begin
      out_ready <= '1;
    end
  end

  // Flits are looked up by their source and the node they came out at
  always @(posedge clk) begin : compare
    logic [FLIT_WIDTH:0] got;
    logic [FLIT_WIDTH:0] want;
    int                  src;
    if (arst_n) begin
      for (int n = 0; n < NODES; n++) begin
        if (out_valid[n] && out_ready[n]) begin
          got = {out_last[n], out_flit[n]};
          src = int'(out_flit[n][SRC_LSB +: NODE_W]);
          // Body flits must come from the packet already open here
          if (cur_src[n] >= 0) begin
            check_value(src, cur_src[n], $sformatf("packet interleaved at node %0d", n));
          end
          if (sb_q[src * NODES + n].size() == 0) begin
            stop_run($sformatf("Unexpected flit at node %0d from node %0d, none outstanding",
                               n, src));
          end
          want = sb_q[src * NODES + n].pop_front();
          check_value(got, want, $sformatf("flit from node %0d at node %0d", src, n));
          cur_src[n] = out_last[n] ? -1 : src;
          received++;
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  initial begin : stimulus
    int  offset;
    int  dest;
    int  len;
    bit  leftover;
    seed         = 18131;
    sent         = 0;
    received     = 0;
    ready_random = 1'b0;
    arst_n       = 1'b0;
    in_flit      = '0;
    in_last      = '0;
    in_valid     = '0;
    out_ready    = '1;
    for (int n = 0; n < NODES; n++) begin
      seq_num[n] = 0;
      cur_src[n] = -1;
    end

    // Outputs idle through reset and just after
    repeat (16) begin
      @(posedge clk);
      check_value(out_valid, '0, "out_valid during reset");
    end
    arst_n <= 1'b1;
    repeat (4) begin
      @(posedge clk);
      check_value(out_valid, '0, "out_valid after reset");
    end

    // Single-flit packet from every node to itself
    for (int n = 0; n < NODES; n++) begin
      queue_packet(n, n, 1);
    end
    drive_all();
    wait_drain();

    // Every source to every destination, shuffled start and random length
    for (int s = 0; s < NODES; s++) begin
      offset = $unsigned($random(seed)) % NODES;
      for (int d = 0; d < NODES; d++) begin
        dest = (d + offset) % NODES;
        len  = 1 + $unsigned($random(seed)) % 4;
        queue_packet(s, dest, len);
      end
    end
    drive_all();
    wait_drain();

    // Hotspot, long packets from all other nodes into node 0
    repeat (3) begin
      for (int s = 1; s < NODES; s++) begin
        queue_packet(s, 0, 3 + $unsigned($random(seed)) % 3);
      end
    end
    drive_all();
    wait_drain();

    // Random traffic again with out_ready toggling
    repeat (2) begin
      for (int s = 0; s < NODES; s++) begin
        for (int d = 0; d < NODES; d++) begin
          dest = $unsigned($random(seed)) % NODES;
          queue_packet(s, dest, 1 + $unsigned($random(seed)) % 4);
        end
      end
    end
    ready_random <= 1'b1;
    drive_all();
    wait_drain();
    ready_random <= 1'b0;
    repeat (10) @(posedge clk);

    leftover = (pending() != 0) || (received != sent);
    if (leftover) begin
      stop_run($sformatf("Scoreboard not empty at the end, sent %0d flits, received %0d",
                         sent, received));
    end else begin
      $display("Test passed");
      $finish;
    end
  end

endmodule

/* list.f */
noc_pkg.sv
noc_input_buffer.sv
noc_route_lookup.sv
noc_output_arbiter.sv
noc_router.sv
noc_mesh3d.sv
tb_noc_mesh3d.sv

/* Makefile */
# Verilator build and run for the 3D mesh NoC testbench
VERILATOR ?= verilator
TOP       ?= tb_noc_mesh3d
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Test failed
VFLAGS    ?= --binary --timing --assert -Wno-fatal

BIN := $(BUILD_DIR)/V$(TOP)
SRCS := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# Fails when the log holds the fail message or the simulation exits with an error
run: compile
	@./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG) || [ $$status -ne 0 ]; then \
	  echo "Simulation reported a failure"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
